/* fetch_pkg.sv */
package fetch_pkg;

   // Instruction word and word-address widths
   localparam int insn_w = 32;
   localparam int pc_w = 30;

   // Opcode sits in the low bits of every instruction
   localparam int op_w = 6;
   // Signed word offset of a relative jump fills the rest
   localparam int jofs_w = insn_w - op_w;

   // Relative jump opcodes, everything else is ordinary
   localparam logic [op_w-1:0] op_jmp = 6'h01;
   localparam logic [op_w-1:0] op_jmpl = 6'h02;
   // Conditional forms test the cc flag
   localparam logic [op_w-1:0] op_bt = 6'h03;
   localparam logic [op_w-1:0] op_bf = 6'h04;

   // Jump view of a word
   typedef struct packed {
      logic [jofs_w-1:0] offset;
      logic [op_w-1:0]   opcode;
   } insn_jmp_t;

   // Register view, 5+5+5+11+6 bits
   typedef struct packed {
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [10:0]     imm;
      logic [op_w-1:0] opcode;
   } insn_reg_t;

   // One 32-bit word, decoded either way
   typedef union packed {
      insn_jmp_t jmp;
      insn_reg_t rr;
   } insn_u;

   // Handed to decode, 32+30+1+1 = 64 bits
   typedef struct packed {
      logic [insn_w-1:0] insn;
      logic [pc_w-1:0]   pc;
      logic              op_jmprel;
      logic              jmprel_link;
   } fetch_out_t;

endpackage

/* fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc
   import fetch_pkg::*;
#(
   // Word address of the first instruction
   parameter logic [pc_w-1:0] reset_vector = '0
) (
   input  logic            clk,
   input  logic            rst,
   // Advance enable, follows bus readiness
   input  logic            load,
   input  logic            jmpfar,
   input  logic [pc_w-1:0] jmpfar_addr,
   input  logic            jmprel_taken,
   input  logic [pc_w-1:0] jmprel_offset,
   // Address of the word now on the bus
   output logic [pc_w-1:0] pc,
   // Address to be fetched next
   output logic [pc_w-1:0] pc_nxt
);

   logic [pc_w-1:0] pc_r;

   // Far jump wins over the relative one
   always_comb begin
      if (jmpfar) begin
         pc_nxt = jmpfar_addr;
      end else if (jmprel_taken) begin
         // Offset is already sign extended
         pc_nxt = pc_r + jmprel_offset;
      end else begin
         pc_nxt = pc_r + 1'b1;
      end
   end

   // Starts one word early so the first increment hits the vector
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_r <= reset_vector - 1'b1;
      end else if (load) begin
         pc_r <= pc_nxt;
      end
   end

   assign pc = pc_r;

endmodule

/* fetch_predecode.sv */
`timescale 1ns/1ps

module fetch_predecode
   import fetch_pkg::*;
(
   input  insn_u           insn,
   // High only for a word being accepted this cycle
   input  logic            insn_valid,
   input  logic            cc,
   output logic            jmprel_taken,
   output logic [pc_w-1:0] jmprel_offset,
   output logic            op_jmprel,
   output logic            jmprel_link
);

   logic [op_w-1:0] opcode;
   // Condition of the jump holds
   logic            cond_ok;

   // Opcode field is common to both views
   assign opcode = insn.jmp.opcode;

   // Widen the 26-bit word offset to a full word address
   assign jmprel_offset = {{(pc_w - jofs_w){insn.jmp.offset[jofs_w-1]}},
                           insn.jmp.offset};

   always_comb begin
      op_jmprel = 1'b0;
      jmprel_link = 1'b0;
      cond_ok = 1'b0;
      case (opcode)
         op_jmp: begin
            op_jmprel = 1'b1;
            cond_ok = 1'b1;
         end
         op_jmpl: begin
            op_jmprel = 1'b1;
            jmprel_link = 1'b1;
            cond_ok = 1'b1;
         end
         // Branch if flag set
         op_bt: begin
            op_jmprel = 1'b1;
            cond_ok = cc;
         end
         // Branch if flag clear
         op_bf: begin
            op_jmprel = 1'b1;
            cond_ok = ~cc;
         end
         default: begin
            // Ordinary instruction, falls through
            cond_ok = 1'b0;
         end
      endcase
   end

   // Stale bus data must not steer the counter
   assign jmprel_taken = insn_valid & op_jmprel & cond_ok;

endmodule

/* fetch_pipebuf.sv */
`timescale 1ns/1ps

module fetch_pipebuf
   import fetch_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // Upstream side
   input  fetch_out_t din,
   input  logic       in_valid,
   output logic       in_ready,
   // Downstream side
   output fetch_out_t dout,
   output logic       out_valid,
   input  logic       out_ready,
   // One pulse per accepted input
   output logic       cas
);

   logic       full;
   fetch_out_t data_r;

   // Room when empty, or when the held entry leaves now
   assign in_ready = ~full | out_ready;
   assign cas = in_valid & in_ready;

   // Occupancy flag
   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (cas) begin
         full <= 1'b1;
      end else if (out_ready) begin
         // Drained with nothing new behind it
         full <= 1'b0;
      end
   end

   // Payload only moves on accept, so it is stable while stalled
   always_ff @(posedge clk) begin
      if (cas) begin
         data_r <= din;
      end
   end

   assign dout = data_r;
   assign out_valid = full;

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
   import fetch_pkg::*;
#(
   parameter logic [pc_w-1:0] reset_vector = '0
) (
   input  logic              clk,
   input  logic              rst,
   // Instruction bus
   input  logic              ibus_valid,
   output logic              ibus_ready,
   output logic [31:0]       ibus_addr,
   input  logic [insn_w-1:0] ibus_insn,
   // Redirect from later stages
   input  logic              jmpfar,
   input  logic [pc_w-1:0]   jmpfar_addr,
   input  logic              cc,
   // Decode port
   input  logic              idu_ready,
   output logic              idu_valid,
   output fetch_out_t        idu_out
);

   logic [pc_w-1:0] pc;
   logic [pc_w-1:0] pc_nxt;
   logic            jmprel_taken;
   logic [pc_w-1:0] jmprel_offset;
   logic            op_jmprel;
   logic            jmprel_link;
   logic            buf_cas;
   fetch_out_t      buf_in;

   // Counter moves whenever the buffer can take a word
   fetch_pc #(
      .reset_vector (reset_vector)
   ) u_fetch_pc (
      .clk           (clk),
      .rst           (rst),
      .load          (ibus_ready),
      .jmpfar        (jmpfar),
      .jmpfar_addr   (jmpfar_addr),
      .jmprel_taken  (jmprel_taken),
      .jmprel_offset (jmprel_offset),
      .pc            (pc),
      .pc_nxt        (pc_nxt)
   );

   // Bus takes byte addresses
   assign ibus_addr = {pc_nxt, 2'b00};

   // Predecode the word arriving now, gated by the accept pulse
   fetch_predecode u_fetch_predecode (
      .insn          (insn_u'(ibus_insn)),
      .insn_valid    (buf_cas),
      .cc            (cc),
      .jmprel_taken  (jmprel_taken),
      .jmprel_offset (jmprel_offset),
      .op_jmprel     (op_jmprel),
      .jmprel_link   (jmprel_link)
   );

   // Word, its address and flags travel together
   assign buf_in = '{insn: ibus_insn, pc: pc, op_jmprel: op_jmprel,
                     jmprel_link: jmprel_link};

   fetch_pipebuf u_fetch_pipebuf (
      .clk       (clk),
      .rst       (rst),
      .din       (buf_in),
      .in_valid  (ibus_valid),
      .in_ready  (ibus_ready),
      .dout      (idu_out),
      .out_valid (idu_valid),
      .out_ready (idu_ready),
      .cas       (buf_cas)
   );

endmodule

/* insn_rom.sv */
`timescale 1ns/1ps

module insn_rom
   import fetch_pkg::*;
#(
   // Array holds 2**depth_log2 words
   parameter int depth_log2 = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   // Fetch side, byte address
   input  logic [31:0]           addr,
   input  logic                  ready,
   output logic                  valid,
   output logic [insn_w-1:0]     rdata,
   // Program load, one word per cycle
   input  logic                  prog_we,
   input  logic [depth_log2-1:0] prog_addr,
   input  logic [insn_w-1:0]     prog_data
);

   localparam int depth = 1 << depth_log2;

   logic [insn_w-1:0]     mem [depth];
   logic [depth_log2-1:0] rd_idx;

   // Drop the byte offset, wrap on the low word bits
   assign rd_idx = addr[depth_log2+1:2];

   // Loader writes
   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

   // Read only while the fetch side can accept
   always_ff @(posedge clk) begin
      if (ready) begin
         rdata <= mem[rd_idx];
      end
   end

   // Valid mirrors ready on each edge where ready is high
   // and holds otherwise, together with rdata
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= 1'b0;
      end else if (ready) begin
         valid <= 1'b1;
      end
   end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
   import fetch_pkg::*;
#(
   parameter logic [pc_w-1:0] reset_vector = '0,
   parameter int              depth_log2 = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cc,
   input  logic                  jmpfar,
   input  logic [pc_w-1:0]       jmpfar_addr,
   input  logic                  idu_ready,
   output logic                  idu_valid,
   output fetch_out_t            idu_out,
   // Testbench program loader
   input  logic                  prog_we,
   input  logic [depth_log2-1:0] prog_addr,
   input  logic [insn_w-1:0]     prog_data
);

   // Instruction bus
   logic              ibus_valid;
   logic              ibus_ready;
   logic [31:0]       ibus_addr;
   logic [insn_w-1:0] ibus_insn;

   insn_rom #(
      .depth_log2 (depth_log2)
   ) u_insn_rom (
      .clk       (clk),
      .rst       (rst),
      .addr      (ibus_addr),
      .ready     (ibus_ready),
      .valid     (ibus_valid),
      .rdata     (ibus_insn),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data)
   );

   fetch_unit #(
      .reset_vector (reset_vector)
   ) u_fetch_unit (
      .clk         (clk),
      .rst         (rst),
      .ibus_valid  (ibus_valid),
      .ibus_ready  (ibus_ready),
      .ibus_addr   (ibus_addr),
      .ibus_insn   (ibus_insn),
      .jmpfar      (jmpfar),
      .jmpfar_addr (jmpfar_addr),
      .cc          (cc),
      .idu_ready   (idu_ready),
      .idu_valid   (idu_valid),
      .idu_out     (idu_out)
   );

endmodule

/* fetch_props.sv */
`timescale 1ns/1ps

module fetch_props
   import fetch_pkg::*;
(
   input logic       clk,
   input logic       rst,
   input logic       idu_valid,
   input logic       idu_ready,
   input fetch_out_t idu_out
);

   // Buffer leaves reset empty
   a_reset_empty: assert property (@(posedge clk) rst |=> !idu_valid)
      else $error("idu_valid high in the cycle after reset");

   // Stalled word stays put until decode takes it
   a_stall_valid: assert property (@(posedge clk) disable iff (rst)
      idu_valid && !idu_ready |=> idu_valid)
      else $error("idu_valid dropped while decode stalled");

   a_stall_data: assert property (@(posedge clk) disable iff (rst)
      idu_valid && !idu_ready |=> $stable(idu_out))
      else $error("idu_out changed while decode stalled");

   // A presented word is never partly undefined
   a_out_known: assert property (@(posedge clk) disable iff (rst)
      idu_valid |-> !$isunknown(idu_out))
      else $error("idu_out has unknown bits while idu_valid is high");

endmodule

/* fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb
   import fetch_pkg::*;
();

   localparam logic [pc_w-1:0] reset_vector = 30'd16;
   localparam int depth_log2 = 8;
   localparam int depth = 1 << depth_log2;

   // Program entry holding word address and contents
   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] word;
   } prog_entry_t;

   // Stimulus step with modes 0 low, 1 high and 2 random
   typedef struct packed {
      logic [1:0]      ready_mode;
      logic [1:0]      cc_mode;
      logic            far;
      logic [pc_w-1:0] target;
      logic [15:0]     cycles;
   } step_t;

   logic                  clk;
   logic                  rst;
   logic                  cc;
   logic                  jmpfar;
   logic [pc_w-1:0]       jmpfar_addr;
   logic                  idu_ready;
   logic                  idu_valid;
   fetch_out_t            idu_out;
   logic                  prog_we;
   logic [depth_log2-1:0] prog_addr;
   logic [insn_w-1:0]     prog_data;

   prog_entry_t     prog_q[$];
   step_t           step_q[$];
   logic [31:0]     image [depth];
   // Reference model state
   logic [pc_w-1:0] m_pc;
   logic            m_bus_valid;
   logic            m_full;
   fetch_out_t      m_buf;
   // Branch outcomes seen in bit order bt taken, bt not, bf taken and bf not
   logic [3:0]      seen = '0;
   int              err_cnt = 0;
   int              n_xfer = 0;
   int              cycle_cnt = 0;
   int              cycle_limit;

   fetch_top #(
      .reset_vector (reset_vector),
      .depth_log2   (depth_log2)
   ) u_fetch_top (
      .clk         (clk),
      .rst         (rst),
      .cc          (cc),
      .jmpfar      (jmpfar),
      .jmpfar_addr (jmpfar_addr),
      .idu_ready   (idu_ready),
      .idu_valid   (idu_valid),
      .idu_out     (idu_out),
      .prog_we     (prog_we),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data)
   );

   bind fetch_top fetch_props u_fetch_props (
      .clk       (clk),
      .rst       (rst),
      .idu_valid (idu_valid),
      .idu_ready (idu_ready),
      .idu_out   (idu_out)
   );

   // Ordinary word built through the register view with every address bit in imm
   function automatic logic [31:0] plain_word(input logic [7:0] a, input logic [2:0] tag);
      insn_u w;
      w.rr.opcode = 6'h3c;
      w.rr.rd = a[4:0];
      w.rr.rs1 = a[7:3];
      w.rr.rs2 = ~a[4:0];
      w.rr.imm = {tag, a};
      return w;
   endfunction

   // Relative jump word with a signed word offset
   function automatic logic [31:0] jump_word(input logic [op_w-1:0] op, input int ofs);
      insn_u w;
      w.jmp.opcode = op;
      w.jmp.offset = ofs[jofs_w-1:0];
      return w;
   endfunction

   // Expected predecode of one word under a given flag
   task automatic predecode_ref(input logic [31:0] w, input logic c, output logic isj,
                                output logic link, output logic taken,
                                output logic [pc_w-1:0] ofs);
      logic [op_w-1:0] op;
      op = w[op_w-1:0];
      isj = (op == op_jmp) || (op == op_jmpl) || (op == op_bt) || (op == op_bf);
      link = (op == op_jmpl);
      taken = (op == op_jmp) || (op == op_jmpl) || (op == op_bt && c) || (op == op_bf && !c);
      ofs = {{(pc_w - jofs_w){w[insn_w-1]}}, w[insn_w-1:op_w]};
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         err_cnt++;
         $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic add_word(input logic [7:0] a, input logic [31:0] w);
      prog_entry_t e;
      e.addr = a;
      e.word = w;
      prog_q.push_back(e);
   endtask

   task automatic add_step(input logic [1:0] rm, input logic [1:0] cm, input logic far,
                           input logic [pc_w-1:0] target, input logic [15:0] cycles);
      step_t s;
      s.ready_mode = rm;
      s.cc_mode = cm;
      s.far = far;
      s.target = target;
      s.cycles = cycles;
      step_q.push_back(s);
   endtask

   // Loop at 16 with forward, backward and conditional jumps
   task automatic build_program();
      add_word(8'd16, plain_word(8'd16, 3'b101));
      add_word(8'd17, plain_word(8'd17, 3'b101));
      add_word(8'd18, jump_word(op_jmp, 4));
      add_word(8'd22, jump_word(op_jmpl, 10));
      add_word(8'd32, plain_word(8'd32, 3'b101));
      add_word(8'd33, jump_word(op_jmp, 20));
      add_word(8'd53, plain_word(8'd53, 3'b101));
      add_word(8'd54, jump_word(op_jmp, -14));
      add_word(8'd40, jump_word(op_bt, 8));
      add_word(8'd41, jump_word(op_bf, 6));
      add_word(8'd42, plain_word(8'd42, 3'b101));
      add_word(8'd43, jump_word(op_jmp, -27));
      add_word(8'd47, plain_word(8'd47, 3'b101));
      add_word(8'd48, jump_word(op_bf, 3));
      add_word(8'd49, plain_word(8'd49, 3'b101));
      add_word(8'd50, jump_word(op_jmp, -34));
      add_word(8'd51, plain_word(8'd51, 3'b101));
      add_word(8'd52, jump_word(op_jmp, -36));
      // Far target linking back to the loop
      add_word(8'd60, plain_word(8'd60, 3'b101));
      add_word(8'd61, jump_word(op_jmpl, -45));
   endtask

   task automatic build_steps();
      add_step(2'd1, 2'd0, 1'b0, '0, 16'd30);
      add_step(2'd1, 2'd1, 1'b0, '0, 16'd30);
      add_step(2'd2, 2'd0, 1'b0, '0, 16'd60);
      // Full stall
      add_step(2'd0, 2'd1, 1'b0, '0, 16'd6);
      add_step(2'd1, 2'd1, 1'b1, 30'd60, 16'd1);
      add_step(2'd1, 2'd1, 1'b0, '0, 16'd20);
      add_step(2'd2, 2'd1, 1'b0, '0, 16'd60);
      // Far into filler words and then back into the loop
      add_step(2'd1, 2'd0, 1'b1, 30'd120, 16'd1);
      add_step(2'd2, 2'd0, 1'b0, '0, 16'd20);
      add_step(2'd1, 2'd1, 1'b1, 30'd40, 16'd1);
      add_step(2'd2, 2'd2, 1'b0, '0, 16'd80);
      add_step(2'd1, 2'd0, 1'b0, '0, 16'd10);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Verification failed");
         $finish;
      end
   end

   // Cycle model evaluated at the falling edge for the coming rising edge
   always @(negedge clk) begin : ref_model
      logic [31:0]     w;
      logic            isj;
      logic            link;
      logic            taken;
      logic            accept;
      logic [pc_w-1:0] ofs;
      logic [pc_w-1:0] nxt;
      fetch_out_t      nb;
      if (rst) begin
         m_pc = reset_vector - 1'b1;
         m_bus_valid = 1'b0;
         m_full = 1'b0;
      end else begin
         check_val("idu_valid", m_full, idu_valid);
         // Held word leaves at the coming edge
         if (m_full && idu_ready) begin
            check_val("idu_out.insn", m_buf.insn, idu_out.insn);
            check_val("idu_out.pc", m_buf.pc, idu_out.pc);
            check_val("idu_out.op_jmprel", m_buf.op_jmprel, idu_out.op_jmprel);
            check_val("idu_out.jmprel_link", m_buf.jmprel_link, idu_out.jmprel_link);
            n_xfer++;
         end
         accept = 1'b0;
         taken = 1'b0;
         // Counter and bus move only when the buffer has room
         if (!m_full || idu_ready) begin
            if (m_bus_valid) begin
               w = image[m_pc[depth_log2-1:0]];
               predecode_ref(w, cc, isj, link, taken, ofs);
               nb = '{insn: w, pc: m_pc, op_jmprel: isj, jmprel_link: link};
               accept = 1'b1;
               if (w[op_w-1:0] == op_bt) begin
                  seen[taken ? 0 : 1] = 1'b1;
               end
               if (w[op_w-1:0] == op_bf) begin
                  seen[taken ? 2 : 3] = 1'b1;
               end
            end
            if (jmpfar) begin
               nxt = jmpfar_addr;
            end else if (taken) begin
               nxt = m_pc + ofs;
            end else begin
               nxt = m_pc + 1'b1;
            end
            m_pc = nxt;
            m_bus_valid = 1'b1;
         end
         if (accept) begin
            m_full = 1'b1;
            m_buf = nb;
         end else if (idu_ready) begin
            m_full = 1'b0;
         end
      end
   end

   initial begin
      int total;
      rst = 1'b1;
      cc = 1'b0;
      jmpfar = 1'b0;
      jmpfar_addr = '0;
      idu_ready = 1'b0;
      prog_we = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      void'($urandom(32'h2513_d4b7));
      build_program();
      build_steps();
      total = 0;
      foreach (step_q[s]) begin
         total += step_q[s].cycles;
      end
      // Load, reset, steps and tail plus some margin
      cycle_limit = depth + total + 50;
      // Filler everywhere with program entries on top
      for (int i = 0; i < depth; i++) begin
         image[i] = plain_word(i[7:0], 3'b011);
      end
      foreach (prog_q[p]) begin
         image[prog_q[p].addr] = prog_q[p].word;
      end
      // Whole image goes in through the load port while in reset
      for (int i = 0; i < depth; i++) begin
         @(posedge clk);
         #1;
         prog_we = 1'b1;
         prog_addr = i[depth_log2-1:0];
         prog_data = image[i];
      end
      @(posedge clk);
      #1;
      prog_we = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (step_q[s]) begin
         for (int c = 0; c < step_q[s].cycles; c++) begin
            idu_ready = (step_q[s].ready_mode == 2'd2) ? ($urandom_range(0, 1) != 0)
                                                       : step_q[s].ready_mode[0];
            cc = (step_q[s].cc_mode == 2'd2) ? ($urandom_range(0, 1) != 0)
                                             : step_q[s].cc_mode[0];
            jmpfar = step_q[s].far;
            jmpfar_addr = step_q[s].target;
            @(posedge clk);
            #1;
         end
      end
      jmpfar = 1'b0;
      idu_ready = 1'b0;
      repeat (2) @(posedge clk);
      if (n_xfer < 120) begin
         err_cnt++;
         $display("Too few words reached decode: only %0d transfers", n_xfer);
      end
      if (seen != 4'hf) begin
         err_cnt++;
         $display("A conditional branch outcome never occurred (seen %b)", seen);
      end
      $display("Transfers checked: %0d, errors: %0d", n_xfer, err_cnt);
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* list.f */
fetch_pkg.sv
fetch_pc.sv
fetch_predecode.sv
fetch_pipebuf.sv
fetch_unit.sv
insn_rom.sv
fetch_top.sv
fetch_props.sv
fetch_tb.sv
